// File: common/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// bus beat and line geometry
`define BUS_W   32
`define LINE_W  128
`define BEATS   4

// header field widths
`define PADR_W  15
`define ID_W    4
`define SIZE_W  16

// one-hot beat mask lives in size[15:12]
`define MASK_HI 15
`define MASK_LO 12

`endif

// File: common/bus_pkg.sv
`include "bus_params.svh"

package bus_pkg;

    // header fields
    typedef logic [`PADR_W-1:0] padr_t;
    typedef logic [`ID_W-1:0]   node_id_t;
    typedef logic [`SIZE_W-1:0] size_t;

    // payload
    typedef logic [`BUS_W-1:0]  beat_t;
    typedef logic [`LINE_W-1:0] line_t;

    // bit k set means words k..0 go out
    typedef logic [`BEATS-1:0]  beat_mask_t;

    // sender states, one flop per state
    typedef enum logic [3:0] {
        FREE       = 4'b0001,
        REQ        = 4'b0010,
        WAIT_GRANT = 4'b0100,
        SEND       = 4'b1000
    } ser_state_t;

endpackage

// File: ser/ser.sv
`timescale 1ns/10ps
`include "bus_params.svh"

module ser (
    input  logic                 clk_bus,
    input  logic                 reset,
    // client side
    input  logic                 valid_in,
    input  bus_pkg::padr_t       padr_in,
    input  bus_pkg::line_t       data_in,
    input  bus_pkg::node_id_t    dest_in,
    input  bus_pkg::node_id_t    return_in,
    input  logic                 rw_in,
    input  bus_pkg::size_t       size_in,
    output logic                 full_block,
    output logic                 free_block,
    // arbiter handshake
    input  logic                 grant,
    input  logic                 ack,
    output logic                 releases,
    output logic                 req,
    // bus fields
    output logic                 valid_bus,
    output bus_pkg::padr_t       padr_bus,
    output bus_pkg::beat_t       data_bus,
    output bus_pkg::node_id_t    return_bus,
    output bus_pkg::node_id_t    dest_bus,
    output logic                 rw_bus,
    output bus_pkg::beat_mask_t  size_bus
);

    bus_pkg::ser_state_t state;
    bus_pkg::ser_state_t state_nxt;
    logic                load;
    logic                sending;
    bus_pkg::line_t      line_q;
    bus_pkg::padr_t      padr_q;
    bus_pkg::node_id_t   dest_q;
    bus_pkg::node_id_t   return_q;
    logic                rw_q;
    bus_pkg::beat_mask_t mask_q;
    bus_pkg::beat_t      word_sel;

    assign free_block = (state == bus_pkg::FREE);
    assign full_block = ~free_block;
    assign load       = valid_in & free_block;
    assign sending    = (state == bus_pkg::SEND);
    assign req        = (state == bus_pkg::REQ);
    // word 0 is always the final beat
    assign releases   = sending & mask_q[0];

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            bus_pkg::FREE: begin
                if (load) begin
                    state_nxt = bus_pkg::REQ;
                end
            end
            bus_pkg::REQ: begin
                if (ack) begin
                    state_nxt = bus_pkg::WAIT_GRANT;
                end
            end
            bus_pkg::WAIT_GRANT: begin
                if (grant) begin
                    state_nxt = bus_pkg::SEND;
                end
            end
            bus_pkg::SEND: begin
                if (mask_q[0]) begin
                    state_nxt = bus_pkg::FREE;
                end
            end
            default: state_nxt = bus_pkg::FREE;
        endcase
    end

    always_ff @(posedge clk_bus) begin
        if (reset) begin
            state <= bus_pkg::FREE;
        end else begin
            state <= state_nxt;
        end
    end

    // header and line captured on accept
    always_ff @(posedge clk_bus) begin
        if (load) begin
            line_q   <= data_in;
            padr_q   <= padr_in;
            dest_q   <= dest_in;
            return_q <= return_in;
            rw_q     <= rw_in;
        end
    end

    // mask walks down one word per beat
    always_ff @(posedge clk_bus) begin
        if (reset) begin
            mask_q <= '0;
        end else if (load) begin
            mask_q <= size_in[`MASK_HI:`MASK_LO];
        end else if (sending) begin
            mask_q <= mask_q >> 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // beat select and bus drive
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        word_sel = '0;
        for (int i = 0; i < `BEATS; i++) begin
            if (mask_q[i]) begin
                word_sel = word_sel | line_q[i*`BUS_W +: `BUS_W];
            end
        end
    end

    // quiet outside SEND
    assign valid_bus  = sending;
    assign padr_bus   = sending ? padr_q : '0;
    assign data_bus   = sending ? word_sel : '0;
    assign return_bus = sending ? return_q : '0;
    assign dest_bus   = sending ? dest_q : '0;
    assign rw_bus     = sending & rw_q;
    assign size_bus   = sending ? mask_q : '0;

endmodule

// File: bau/bau.sv
`timescale 1ns/10ps

module bau (
    input  logic                 clk_bus,
    input  logic                 reset,
    input  logic                 req0,
    input  logic                 req1,
    input  logic                 releases0,
    input  logic                 releases1,
    output logic                 ack0,
    output logic                 ack1,
    output logic                 grant0,
    output logic                 grant1,
    // sender 0 bus fields
    input  logic                 valid_bus0,
    input  bus_pkg::padr_t       padr_bus0,
    input  bus_pkg::beat_t       data_bus0,
    input  bus_pkg::node_id_t    return_bus0,
    input  bus_pkg::node_id_t    dest_bus0,
    input  logic                 rw_bus0,
    input  bus_pkg::beat_mask_t  size_bus0,
    // sender 1 bus fields
    input  logic                 valid_bus1,
    input  bus_pkg::padr_t       padr_bus1,
    input  bus_pkg::beat_t       data_bus1,
    input  bus_pkg::node_id_t    return_bus1,
    input  bus_pkg::node_id_t    dest_bus1,
    input  logic                 rw_bus1,
    input  bus_pkg::beat_mask_t  size_bus1,
    // steered bus
    output logic                 valid_bus,
    output bus_pkg::padr_t       padr_bus,
    output bus_pkg::beat_t       data_bus,
    output bus_pkg::node_id_t    return_bus,
    output bus_pkg::node_id_t    dest_bus,
    output logic                 rw_bus,
    output bus_pkg::beat_mask_t  size_bus
);

    logic pend0;
    logic pend1;
    // high when sender 1 has priority for the next grant
    logic rr;
    logic idle;
    logic pick0;
    logic pick1;

    assign idle  = ~grant0 & ~grant1;
    assign pick0 = idle & pend0 & (~pend1 | ~rr);
    assign pick1 = idle & pend1 & (~pend0 | rr);

    ////////////////////////////////////////////////////////////////////////////
    // request queuing and grant
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_bus) begin
        if (reset) begin
            ack0   <= 1'b0;
            ack1   <= 1'b0;
            pend0  <= 1'b0;
            pend1  <= 1'b0;
            grant0 <= 1'b0;
            grant1 <= 1'b0;
            rr     <= 1'b0;
        end else begin
            // single-cycle ack, sender leaves REQ on it
            ack0 <= req0 & ~ack0;
            ack1 <= req1 & ~ack1;

            if (pick0) begin
                pend0 <= 1'b0;
            end else if (ack0) begin
                pend0 <= 1'b1;
            end
            if (pick1) begin
                pend1 <= 1'b0;
            end else if (ack1) begin
                pend1 <= 1'b1;
            end

            // grant drops the cycle after the last beat
            if (grant0 & releases0) begin
                grant0 <= 1'b0;
            end else if (pick0) begin
                grant0 <= 1'b1;
            end
            if (grant1 & releases1) begin
                grant1 <= 1'b0;
            end else if (pick1) begin
                grant1 <= 1'b1;
            end

            if (pick0) begin
                rr <= 1'b1;
            end else if (pick1) begin
                rr <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // field mux
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        valid_bus  = (grant0 & valid_bus0) | (grant1 & valid_bus1);
        padr_bus   = '0;
        data_bus   = '0;
        return_bus = '0;
        dest_bus   = '0;
        rw_bus     = 1'b0;
        size_bus   = '0;
        if (valid_bus) begin
            padr_bus   = grant1 ? padr_bus1 : padr_bus0;
            data_bus   = grant1 ? data_bus1 : data_bus0;
            return_bus = grant1 ? return_bus1 : return_bus0;
            dest_bus   = grant1 ? dest_bus1 : dest_bus0;
            rw_bus     = grant1 ? rw_bus1 : rw_bus0;
            size_bus   = grant1 ? size_bus1 : size_bus0;
        end
    end

endmodule

// File: des/des.sv
`timescale 1ns/10ps
`include "bus_params.svh"

module des (
    input  logic                 clk_bus,
    input  logic                 reset,
    input  logic                 valid_bus,
    input  bus_pkg::padr_t       padr_bus,
    input  bus_pkg::beat_t       data_bus,
    input  bus_pkg::node_id_t    return_bus,
    input  bus_pkg::node_id_t    dest_bus,
    input  logic                 rw_bus,
    input  bus_pkg::beat_mask_t  size_bus,
    output logic                 line_valid,
    output bus_pkg::padr_t       line_padr,
    output bus_pkg::line_t       line_data,
    output bus_pkg::node_id_t    line_dest,
    output bus_pkg::node_id_t    line_return,
    output logic                 line_rw,
    output bus_pkg::beat_mask_t  line_mask
);

    // set between the first and the last beat
    logic           in_xfer;
    logic           first;
    logic           last;
    bus_pkg::line_t line_nxt;

    assign first = valid_bus & ~in_xfer;
    assign last  = valid_bus & size_bus[0];

    // new transfer starts from an empty line
    always_comb begin
        line_nxt = first ? '0 : line_data;
        for (int i = 0; i < `BEATS; i++) begin
            if (valid_bus & size_bus[i]) begin
                line_nxt[i*`BUS_W +: `BUS_W] = data_bus;
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (reset) begin
            in_xfer    <= 1'b0;
            line_valid <= 1'b0;
        end else begin
            line_valid <= last;
            if (valid_bus) begin
                in_xfer <= ~size_bus[0];
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (valid_bus) begin
            line_data <= line_nxt;
        end
        // header and original mask come with the first beat
        if (first) begin
            line_padr   <= padr_bus;
            line_dest   <= dest_bus;
            line_return <= return_bus;
            line_rw     <= rw_bus;
            line_mask   <= size_bus;
        end
    end

endmodule

// File: hdl/bus_subsys.sv
`timescale 1ns/10ps

module bus_subsys (
    input  logic                 clk_bus,
    input  logic                 reset,
    // client 0
    input  logic                 valid_in0,
    input  bus_pkg::padr_t       padr_in0,
    input  bus_pkg::line_t       data_in0,
    input  bus_pkg::node_id_t    dest_in0,
    input  bus_pkg::node_id_t    return_in0,
    input  logic                 rw_in0,
    input  bus_pkg::size_t       size_in0,
    output logic                 full_block0,
    output logic                 free_block0,
    // client 1
    input  logic                 valid_in1,
    input  bus_pkg::padr_t       padr_in1,
    input  bus_pkg::line_t       data_in1,
    input  bus_pkg::node_id_t    dest_in1,
    input  bus_pkg::node_id_t    return_in1,
    input  logic                 rw_in1,
    input  bus_pkg::size_t       size_in1,
    output logic                 full_block1,
    output logic                 free_block1,
    // rebuilt line
    output logic                 line_valid,
    output bus_pkg::padr_t       line_padr,
    output bus_pkg::line_t       line_data,
    output bus_pkg::node_id_t    line_dest,
    output bus_pkg::node_id_t    line_return,
    output logic                 line_rw,
    output bus_pkg::beat_mask_t  line_mask
);

    logic                req0, req1, ack0, ack1;
    logic                grant0, grant1, releases0, releases1;
    logic                valid_bus0, valid_bus1, valid_bus;
    bus_pkg::padr_t      padr_bus0, padr_bus1, padr_bus;
    bus_pkg::beat_t      data_bus0, data_bus1, data_bus;
    bus_pkg::node_id_t   return_bus0, return_bus1, return_bus;
    bus_pkg::node_id_t   dest_bus0, dest_bus1, dest_bus;
    logic                rw_bus0, rw_bus1, rw_bus;
    bus_pkg::beat_mask_t size_bus0, size_bus1, size_bus;

    ser ser0 (
        .clk_bus(clk_bus), .reset(reset),
        .valid_in(valid_in0), .padr_in(padr_in0), .data_in(data_in0),
        .dest_in(dest_in0), .return_in(return_in0), .rw_in(rw_in0),
        .size_in(size_in0), .full_block(full_block0), .free_block(free_block0),
        .grant(grant0), .ack(ack0), .releases(releases0), .req(req0),
        .valid_bus(valid_bus0), .padr_bus(padr_bus0), .data_bus(data_bus0),
        .return_bus(return_bus0), .dest_bus(dest_bus0), .rw_bus(rw_bus0),
        .size_bus(size_bus0)
    );

    ser ser1 (
        .clk_bus(clk_bus), .reset(reset),
        .valid_in(valid_in1), .padr_in(padr_in1), .data_in(data_in1),
        .dest_in(dest_in1), .return_in(return_in1), .rw_in(rw_in1),
        .size_in(size_in1), .full_block(full_block1), .free_block(free_block1),
        .grant(grant1), .ack(ack1), .releases(releases1), .req(req1),
        .valid_bus(valid_bus1), .padr_bus(padr_bus1), .data_bus(data_bus1),
        .return_bus(return_bus1), .dest_bus(dest_bus1), .rw_bus(rw_bus1),
        .size_bus(size_bus1)
    );

    bau bau (
        .clk_bus(clk_bus), .reset(reset),
        .req0(req0), .req1(req1), .releases0(releases0), .releases1(releases1),
        .ack0(ack0), .ack1(ack1), .grant0(grant0), .grant1(grant1),
        .valid_bus0(valid_bus0), .padr_bus0(padr_bus0), .data_bus0(data_bus0),
        .return_bus0(return_bus0), .dest_bus0(dest_bus0), .rw_bus0(rw_bus0),
        .size_bus0(size_bus0),
        .valid_bus1(valid_bus1), .padr_bus1(padr_bus1), .data_bus1(data_bus1),
        .return_bus1(return_bus1), .dest_bus1(dest_bus1), .rw_bus1(rw_bus1),
        .size_bus1(size_bus1),
        .valid_bus(valid_bus), .padr_bus(padr_bus), .data_bus(data_bus),
        .return_bus(return_bus), .dest_bus(dest_bus), .rw_bus(rw_bus),
        .size_bus(size_bus)
    );

    des des (
        .clk_bus(clk_bus), .reset(reset),
        .valid_bus(valid_bus), .padr_bus(padr_bus), .data_bus(data_bus),
        .return_bus(return_bus), .dest_bus(dest_bus), .rw_bus(rw_bus),
        .size_bus(size_bus),
        .line_valid(line_valid), .line_padr(line_padr), .line_data(line_data),
        .line_dest(line_dest), .line_return(line_return), .line_rw(line_rw),
        .line_mask(line_mask)
    );

endmodule

// File: tests/bus_subsys_assert.sv
`timescale 1ns/10ps

module bus_subsys_assert (
    input logic                clk_bus,
    input logic                reset,
    input logic                req0,
    input logic                req1,
    input logic                ack0,
    input logic                ack1,
    input logic                grant0,
    input logic                grant1,
    input logic                valid_bus0,
    input logic                valid_bus1,
    input logic                valid_bus,
    input bus_pkg::beat_mask_t size_bus
);

    // single bus owner
    grant_onehot: assert property (@(posedge clk_bus) disable iff (reset)
        !(grant0 && grant1))
        else $error("grant0 and grant1 high together");

    // beats only from the owner
    valid0_granted: assert property (@(posedge clk_bus) disable iff (reset)
        valid_bus0 |-> grant0)
        else $error("sender 0 drives the bus without grant0");
    valid1_granted: assert property (@(posedge clk_bus) disable iff (reset)
        valid_bus1 |-> grant1)
        else $error("sender 1 drives the bus without grant1");

    mask_onehot: assert property (@(posedge clk_bus) disable iff (reset)
        valid_bus |-> $onehot(size_bus))
        else $error("size_bus not one-hot on a beat");

    // ack one cycle after req
    ack0_follows: assert property (@(posedge clk_bus) disable iff (reset)
        $rose(req0) |=> ack0)
        else $error("ack0 missing after req0");
    ack1_follows: assert property (@(posedge clk_bus) disable iff (reset)
        $rose(req1) |=> ack1)
        else $error("ack1 missing after req1");

endmodule

// File: tests/bus_subsys_tb.sv
`timescale 1ns/10ps
`include "bus_params.svh"

module bus_subsys_tb;

    localparam int NUM_TRANS   = 49;
    localparam int CYCLE_LIMIT = 60 * NUM_TRANS + 100;
    localparam int RAND_TRANS  = 40;
    localparam bus_pkg::node_id_t RET_ID0 = 4'h5;
    localparam bus_pkg::node_id_t RET_ID1 = 4'hA;

    logic                clk_bus = 1'b0;
    logic                reset;
    logic                valid_in0, valid_in1, rw_in0, rw_in1;
    bus_pkg::padr_t      padr_in0, padr_in1;
    bus_pkg::line_t      data_in0, data_in1;
    bus_pkg::node_id_t   dest_in0, dest_in1, return_in0, return_in1;
    bus_pkg::size_t      size_in0, size_in1;
    logic                full_block0, free_block0, full_block1, free_block1;
    logic                line_valid, line_rw;
    bus_pkg::padr_t      line_padr;
    bus_pkg::line_t      line_data;
    bus_pkg::node_id_t   line_dest, line_return;
    bus_pkg::beat_mask_t line_mask;

    int seed;
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int accept_cycle;
    int line_cycle;
    int arrivals [$];

    // expected lines per sender, oldest first
    bus_pkg::line_t      exp_data [2][$];
    bus_pkg::padr_t      exp_padr [2][$];
    bus_pkg::node_id_t   exp_dest [2][$];
    logic                exp_rw   [2][$];
    bus_pkg::beat_mask_t exp_mask [2][$];

    // random stream, drawn up front
    int                  rnd_sender [RAND_TRANS];
    logic [1:0]          rnd_gap    [RAND_TRANS];
    bus_pkg::padr_t      rnd_padr   [RAND_TRANS];
    bus_pkg::line_t      rnd_data   [RAND_TRANS];
    bus_pkg::node_id_t   rnd_dest   [RAND_TRANS];
    logic                rnd_rw     [RAND_TRANS];
    bus_pkg::size_t      rnd_size   [RAND_TRANS];

    bus_subsys bus_subsys_i (
        .clk_bus(clk_bus), .reset(reset),
        .valid_in0(valid_in0), .padr_in0(padr_in0), .data_in0(data_in0),
        .dest_in0(dest_in0), .return_in0(return_in0), .rw_in0(rw_in0),
        .size_in0(size_in0), .full_block0(full_block0), .free_block0(free_block0),
        .valid_in1(valid_in1), .padr_in1(padr_in1), .data_in1(data_in1),
        .dest_in1(dest_in1), .return_in1(return_in1), .rw_in1(rw_in1),
        .size_in1(size_in1), .full_block1(full_block1), .free_block1(free_block1),
        .line_valid(line_valid), .line_padr(line_padr), .line_data(line_data),
        .line_dest(line_dest), .line_return(line_return), .line_rw(line_rw),
        .line_mask(line_mask)
    );

    bind bau bus_subsys_assert bau_assert_i (
        .clk_bus(clk_bus), .reset(reset),
        .req0(req0), .req1(req1), .ack0(ack0), .ack1(ack1),
        .grant0(grant0), .grant1(grant1),
        .valid_bus0(valid_bus0), .valid_bus1(valid_bus1),
        .valid_bus(valid_bus), .size_bus(size_bus)
    );

    always #20 clk_bus = ~clk_bus;

    always @(posedge clk_bus) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, lines still outstanding", cycle);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // reference model and compare tasks
    //////////////////////////////////////////////////////////////////////////////
    // words k..0 survive, k is the set mask bit
    function automatic bus_pkg::line_t expect_line(input bus_pkg::line_t data,
                                                   input bus_pkg::beat_mask_t mask);
        bus_pkg::line_t line;
        logic           keep;
        line = '0;
        keep = 1'b0;
        for (int i = `BEATS - 1; i >= 0; i--) begin
            keep = keep | mask[i];
            if (keep) begin
                line[i*`BUS_W +: `BUS_W] = data[i*`BUS_W +: `BUS_W];
            end
        end
        return line;
    endfunction

    task automatic compare_line(input string name, input bus_pkg::line_t got,
                                input bus_pkg::line_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_padr(input string name, input bus_pkg::padr_t got,
                                input bus_pkg::padr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_id(input string name, input bus_pkg::node_id_t got,
                              input bus_pkg::node_id_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_mask(input string name, input bus_pkg::beat_mask_t got,
                                input bus_pkg::beat_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // each rebuilt line goes to the queue named by its return id
    always @(negedge clk_bus) begin
        int s;
        if (line_valid) begin
            s = (line_return == RET_ID1) ? 1 : 0;
            line_cycle = cycle;
            if (line_return != RET_ID0 && line_return != RET_ID1) begin
                errors++;
                $display("line arrived with unknown return id %h", line_return);
            end else if (exp_data[s].size() == 0) begin
                errors++;
                $display("line arrived from sender %0d with nothing outstanding", s);
            end else begin
                arrivals.push_back(s);
                compare_line("line_data", line_data, exp_data[s].pop_front());
                compare_padr("line_padr", line_padr, exp_padr[s].pop_front());
                compare_id("line_dest", line_dest, exp_dest[s].pop_front());
                compare_flag("line_rw", line_rw, exp_rw[s].pop_front());
                compare_mask("line_mask", line_mask, exp_mask[s].pop_front());
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////////////
    task automatic drive_client(input int s, input logic valid, input bus_pkg::padr_t padr,
                                input bus_pkg::line_t data, input bus_pkg::node_id_t dest,
                                input logic rw, input bus_pkg::size_t size);
        if (s == 0) begin
            valid_in0  = valid;
            padr_in0   = padr;
            data_in0   = data;
            dest_in0   = dest;
            return_in0 = RET_ID0;
            rw_in0     = rw;
            size_in0   = size;
        end else begin
            valid_in1  = valid;
            padr_in1   = padr;
            data_in1   = data;
            dest_in1   = dest;
            return_in1 = RET_ID1;
            rw_in1     = rw;
            size_in1   = size;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the strobe
    task automatic send_line(input int s, input bus_pkg::padr_t padr,
                             input bus_pkg::line_t data, input bus_pkg::node_id_t dest,
                             input logic rw, input bus_pkg::size_t size);
        while (!(s == 0 ? free_block0 : free_block1)) begin
            @(negedge clk_bus);
        end
        drive_client(s, 1'b1, padr, data, dest, rw, size);
        exp_data[s].push_back(expect_line(data, size[`MASK_HI:`MASK_LO]));
        exp_padr[s].push_back(padr);
        exp_dest[s].push_back(dest);
        exp_rw[s].push_back(rw);
        exp_mask[s].push_back(size[`MASK_HI:`MASK_LO]);
        accept_cycle = cycle + 1;
        @(negedge clk_bus);
        drive_client(s, 1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic wait_idle();
        while (exp_data[0].size() != 0 || exp_data[1].size() != 0) begin
            @(negedge clk_bus);
        end
    endtask

    task automatic run_stream(input int s);
        for (int i = 0; i < RAND_TRANS; i++) begin
            if (rnd_sender[i] == s) begin
                repeat (rnd_gap[i]) @(negedge clk_bus);
                send_line(s, rnd_padr[i], rnd_data[i], rnd_dest[i], rnd_rw[i], rnd_size[i]);
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        seed  = 32'h2025_33b7;
        reset = 1'b1;
        drive_client(0, 1'b0, '0, '0, '0, 1'b0, '0);
        drive_client(1, 1'b0, '0, '0, '0, 1'b0, '0);
        for (int i = 0; i < RAND_TRANS; i++) begin
            r = $random(seed);
            rnd_sender[i] = r[0] ? 1 : 0;
            rnd_gap[i]    = r[2:1];
            rnd_rw[i]     = r[3];
            rnd_dest[i]   = r[7:4];
            rnd_padr[i]   = r[22:8];
            rnd_size[i]   = {4'b0001 << r[25:24], r[11:0]};
            for (int w = 0; w < `BEATS; w++) begin
                rnd_data[i][w*`BUS_W +: `BUS_W] = $random(seed);
            end
        end
        repeat (2) @(posedge clk_bus);
        @(negedge clk_bus);
        reset = 1'b0;

        // quiet after reset
        compare_flag("free_block0", free_block0, 1'b1);
        compare_flag("free_block1", free_block1, 1'b1);
        compare_flag("full_block0", full_block0, 1'b0);
        compare_flag("full_block1", full_block1, 1'b0);
        repeat (10) begin
            @(negedge clk_bus);
            compare_flag("line_valid", line_valid, 1'b0);
        end
        finish_test("reset state");

        send_line(0, 15'h1234, 128'h0123_4567_89ab_cdef_0f1e_2d3c_4b5a_6978, 4'h3, 1'b1,
                  16'h8abc);
        wait_idle();
        checks++;
        if (line_cycle - accept_cycle != 8) begin
            errors++;
            $display("single line took %0d cycles from accept, expected 8",
                     line_cycle - accept_cycle);
        end
        finish_test("single line");

        // short masks, low size bits set to show they are ignored
        for (int k = 0; k < 3; k++) begin
            send_line(k % 2, 15'h0040, 128'hdead_beef_cafe_f00d_1357_9bdf_2468_ace0, 4'h6,
                      1'b0, {4'b0001 << k, 12'hfff});
            wait_idle();
        end
        finish_test("short masks");

        send_line(0, 15'h0777, 128'h1111_2222_3333_4444_5555_6666_7777_8888, 4'h9, 1'b0,
                  16'h8000);
        compare_flag("full_block0", full_block0, 1'b1);
        drive_client(0, 1'b1, 15'h7fff, 128'hffff_0000_ffff_0000_ffff_0000_ffff_0000,
                     4'h1, 1'b1, 16'h1000);
        @(negedge clk_bus);
        drive_client(0, 1'b0, '0, '0, '0, 1'b0, '0);
        wait_idle();
        compare_flag("free_block0", free_block0, 1'b1);
        repeat (12) @(negedge clk_bus);
        finish_test("busy strobe");

        // both senders loaded together
        // last owner so far heads the list, the first grant must turn away from it
        while (arrivals.size() > 1) begin
            void'(arrivals.pop_front());
        end
        fork
            begin
                send_line(0, 15'h0100, {4{32'h0a0a_0a0a}}, 4'h2, 1'b1, 16'h8000);
                send_line(0, 15'h0104, {4{32'h0b0b_0b0b}}, 4'h2, 1'b0, 16'h8000);
            end
            begin
                send_line(1, 15'h0200, {4{32'h1a1a_1a1a}}, 4'h4, 1'b0, 16'h8000);
                send_line(1, 15'h0204, {4{32'h1b1b_1b1b}}, 4'h4, 1'b1, 16'h8000);
            end
        join
        wait_idle();
        for (int i = 1; i < arrivals.size(); i++) begin
            checks++;
            if (arrivals[i] == arrivals[i-1]) begin
                errors++;
                $display("bus owners did not alternate at line %0d", i);
            end
        end
        finish_test("two senders");

        fork
            run_stream(0);
            run_stream(1);
        join
        wait_idle();
        finish_test("random stream");

        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+common
common/bus_pkg.sv
ser/ser.sv
bau/bau.sv
des/des.sv
hdl/bus_subsys.sv
tests/bus_subsys_assert.sv
tests/bus_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bus_subsys_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
FAIL_MSG  ?= CHECKS FAILED

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST))) common/bus_params.svh
EXE  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@./$(EXE) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
